// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module usb_bulk_tb -f usb_bulk.f &&
  ./obj_dir/Vusb_bulk_tb 2>&1 | tee sim.log
grep -qx "Simulation PASSED" sim.log && echo "run_sim: pass" || {
  echo "run_sim: fail, see sim.log"
  exit 1
}

// ==== test/usb_bulk_stimulus.txt ====
// columns: op addr endp pid len expect (hex); expect 0 none, 2 ACK, a NAK, 3/b data PID
// op: 1 out, 2 token (pid column is the token PID), 3 in, 4 in without host ACK,
//     5 load IN packet, 6 drain OUT packet, 7 configure (len is the level), 8 address, 0 end
8 05 0 0 00 0  // device address 5
1 05 1 3 04 0  // not configured yet
7 00 0 0 01 0
1 06 1 3 04 0  // wrong address
1 05 3 3 04 0  // wrong endpoint
2 05 1 5 00 0  // SOF is ignored
3 05 1 0 00 0  // IN to the OUT endpoint
3 05 2 0 00 a  // nothing loaded
1 05 1 3 08 2
1 05 1 b 05 a  // first packet not drained
2 05 1 4 00 a  // PING while full
6 00 0 0 00 0
2 05 1 4 00 2
1 05 1 3 06 2  // repeated DATA0, dropped
6 00 0 0 00 0
1 05 1 b 0c 2
6 00 0 0 00 0
5 00 0 0 10 0
4 05 2 0 00 3  // host ACK lost
3 05 2 0 00 3  // same bytes again
5 00 0 0 09 0
3 05 2 0 00 b
1 05 1 3 03 2
6 00 0 0 00 0
5 00 0 0 07 0
3 05 2 0 00 3
7 00 0 0 00 0  // deconfigure clears both toggles
7 00 0 0 01 0
1 05 1 3 05 2
6 00 0 0 00 0
5 00 0 0 04 0
3 05 2 0 00 3
0 00 0 0 00 0

// ==== test/usb_bulk_tb.sv ====
module usb_bulk_tb
  import usb_bulk_pkg::*;
();

  localparam integer TIMEOUT = 300;  // cycles per wait loop
  localparam integer NWORDS = 6 * 48;  // six columns per line

  logic         clock;
  logic         reset;
  logic [6:0]   usb_addr_i;
  logic         configured_i;
  usb_token_t   tok_i;
  usb_rx_t      rx_i;
  logic         hsk_ack_i;
  usb_hsk_t     hsk_o;
  usb_tx_t      tx_o;
  logic         tx_ready_i;
  byte_stream_t blko_o;
  logic         blko_ready_i;
  byte_stream_t blki_i;
  logic         blki_ready_o;

  logic [31:0] stim [NWORDS];
  logic [31:0] rng;
  logic [7:0]  pkt[$];  // payload being sent or loaded
  logic [7:0]  out_exp[$];
  logic        out_last_exp[$];
  logic [7:0]  in_exp[$];  // bytes held by the IN endpoint
  logic        out_tog;  // expected OUT data toggle
  integer      mismatches;
  integer      timeouts;
  integer      others;

  usb_bulk_top #(
    .MAX_PKT(MAX_PKT_DEFAULT)
  ) u_usb_bulk_top (
    .*
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      mismatches = mismatches + 1;
      $display("Mismatch %s: got %h expected %h at %0t", what, got, exp, $time);
    end
  endtask

  task automatic note_timeout(input logic ok, input string what);
    assert (ok) else begin
      timeouts = timeouts + 1;
      $display("Timed out waiting for %s at %0t", what, $time);
    end
  endtask

  task automatic make_payload(input integer len);
    integer i;
    pkt.delete();
    for (i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      pkt.push_back(rng[7:0]);
    end
  endtask

  task automatic send_token(input usb_pid_e pid, input logic [6:0] addr, input logic [3:0] endp);
    @(negedge clock);
    tok_i.valid = 1'b1;
    tok_i.pid = pid;
    tok_i.addr = addr;
    tok_i.endp = endp;
    @(negedge clock);
    tok_i.valid = 1'b0;  // sampled on the edge just passed
  endtask

  task automatic send_data(input usb_pid_e pid);
    integer i;
    for (i = 0; i < pkt.size(); i++) begin
      rx_i.valid = 1'b1;
      rx_i.last = (i == pkt.size() - 1);
      rx_i.pid = pid;
      rx_i.data = pkt[i];
      @(negedge clock);
    end
    rx_i.valid = 1'b0;
    rx_i.last = 1'b0;
  endtask

  // called one cycle after the token or the last data byte
  task automatic check_hsk(input logic [3:0] exp);
    if (exp == 4'h0) begin
      repeat (4) begin
        assert (!hsk_o.valid && !tx_o.valid) else begin
          others = others + 1;
          $display("A token that should be ignored got an answer at %0t", $time);
        end
        @(negedge clock);
      end
    end else begin
      check_eq("hsk_o.valid", 32'(hsk_o.valid), 32'd1);
      check_eq("hsk_o.pid", 32'(hsk_o.pid), 32'(exp));
    end
  endtask

  task automatic out_transfer(input logic [6:0] addr, input logic [3:0] endp,
                              input logic [3:0] pid, input integer len, input logic [3:0] exp);
    integer k;
    make_payload(len);
    send_token(PID_OUT, addr, endp);
    send_data(usb_pid_e'(pid));
    check_hsk(exp);
    // ACK with the expected toggle means delivery, otherwise a duplicate
    if (exp == PID_ACK && pid == (out_tog ? PID_DATA1 : PID_DATA0)) begin
      for (k = 0; k < len; k++) begin
        out_exp.push_back(pkt[k]);
        out_last_exp.push_back(k == len - 1);
      end
      out_tog = ~out_tog;
    end
  endtask

  task automatic receive_packet(input logic [3:0] exp);
    integer n;
    integer cnt;
    logic done;
    n = 0;
    cnt = 0;
    done = 1'b0;
    while (!done && cnt < TIMEOUT) begin
      rng = xorshift32(rng);
      tx_ready_i = rng[0];  // random back-pressure
      if (tx_o.valid && tx_ready_i) begin
        check_eq("tx_o.pid", 32'(tx_o.pid), 32'(exp));
        if (n < in_exp.size()) begin
          check_eq("tx_o.data", 32'(tx_o.data), 32'(in_exp[n]));
          check_eq("tx_o.last", 32'(tx_o.last), 32'(n == in_exp.size() - 1));
        end else begin
          others = others + 1;
          $display("tx_o sent more bytes than were loaded at %0t", $time);
        end
        n = n + 1;
        done = tx_o.last;
      end
      cnt = cnt + 1;
      @(negedge clock);
    end
    tx_ready_i = 1'b0;
    note_timeout(done, "the last byte on tx_o");
  endtask

  task automatic in_transfer(input logic [6:0] addr, input logic [3:0] endp,
                             input logic [3:0] exp, input logic host_ack);
    send_token(PID_IN, addr, endp);
    if (exp == PID_DATA0 || exp == PID_DATA1) begin
      receive_packet(exp);
      if (host_ack) begin
        hsk_ack_i = 1'b1;
        @(negedge clock);
        hsk_ack_i = 1'b0;
        in_exp.delete();
        check_eq("blki_ready_o", 32'(blki_ready_o), 32'd1);  // buffer released
      end
    end else begin
      check_hsk(exp);
    end
  endtask

  task automatic load_packet(input integer len);
    integer n;
    integer cnt;
    make_payload(len);
    in_exp = pkt;
    n = 0;
    cnt = 0;
    while (n < len && cnt < TIMEOUT) begin
      blki_i.valid = 1'b1;
      blki_i.last = (n == len - 1);
      blki_i.data = pkt[n];
      if (blki_ready_o) n = n + 1;  // taken on the next edge
      cnt = cnt + 1;
      @(negedge clock);
    end
    blki_i.valid = 1'b0;
    note_timeout(n == len, "blki_ready_o");
    check_eq("blki_ready_o", 32'(blki_ready_o), 32'd0);
  endtask

  task automatic drain_out();
    integer cnt;
    cnt = 0;
    while (out_exp.size() > 0 && cnt < TIMEOUT) begin
      rng = xorshift32(rng);
      blko_ready_i = rng[0];
      if (blko_o.valid && blko_ready_i) begin
        check_eq("blko_o.data", 32'(blko_o.data), 32'(out_exp.pop_front()));
        check_eq("blko_o.last", 32'(blko_o.last), 32'(out_last_exp.pop_front()));
      end
      cnt = cnt + 1;
      @(negedge clock);
    end
    note_timeout(out_exp.size() == 0, "the OUT packet on blko_o");
    blko_ready_i = 1'b1;
    repeat (6) begin
      assert (!blko_o.valid) else begin
        others = others + 1;
        $display("blko_o delivered a byte that no accepted packet holds at %0t", $time);
      end
      @(negedge clock);
    end
    blko_ready_i = 1'b0;  // keep later packets in the buffer
  endtask

  task automatic run_line(input logic [3:0] op, input logic [6:0] addr, input logic [3:0] endp,
                          input logic [3:0] pid, input integer len, input logic [3:0] exp);
    case (op)
      4'h1: out_transfer(addr, endp, pid, len, exp);
      4'h2: begin
        send_token(usb_pid_e'(pid), addr, endp);
        check_hsk(exp);
      end
      4'h3: in_transfer(addr, endp, exp, 1'b1);
      4'h4: in_transfer(addr, endp, exp, 1'b0);
      4'h5: load_packet(len);
      4'h6: drain_out();
      4'h7: begin
        configured_i = len[0];
        if (!len[0]) out_tog = 1'b0;
        @(negedge clock);
      end
      4'h8: begin
        usb_addr_i = addr;
        @(negedge clock);
      end
      default: begin
        others = others + 1;
        $display("Unknown operation %h in the stimulus file", op);
      end
    endcase
  endtask

  initial begin
    integer idx;
    reset = 1'b1;
    usb_addr_i = '0;
    configured_i = 1'b0;
    tok_i = '0;
    rx_i = '0;
    hsk_ack_i = 1'b0;
    tx_ready_i = 1'b0;
    blko_ready_i = 1'b0;
    blki_i = '0;
    mismatches = 0;
    timeouts = 0;
    others = 0;
    out_tog = 1'b0;
    rng = 32'hef2283db;
    foreach (stim[k]) stim[k] = '0;
    $readmemh("test/usb_bulk_stimulus.txt", stim);
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_eq("hsk_o.valid", 32'(hsk_o.valid), 32'd0);
    check_eq("tx_o.valid", 32'(tx_o.valid), 32'd0);
    check_eq("blko_o.valid", 32'(blko_o.valid), 32'd0);
    check_eq("blki_ready_o", 32'(blki_ready_o), 32'd1);
    for (idx = 0; idx < NWORDS; idx += 6) begin
      if (stim[idx] == 32'h0) break;
      run_line(stim[idx][3:0], stim[idx + 1][6:0], stim[idx + 2][3:0], stim[idx + 3][3:0],
               stim[idx + 4], stim[idx + 5][3:0]);
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts, others);
    if (mismatches + timeouts + others == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== usb_bulk.f ====
verilog/usb_bulk_pkg.sv
verilog/packet_buffer.sv
verilog/ep_bulk_out.sv
verilog/ep_bulk_in.sv
verilog/bulk_protocol.sv
verilog/usb_bulk_top.sv
test/usb_bulk_tb.sv

// ==== verilog/bulk_protocol.sv ====
module bulk_protocol
  import usb_bulk_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic [6:0] usb_addr_i,
  input  logic       configured_i,
  input  usb_token_t tok_i,
  input  usb_rx_t    rx_i,
  input  logic       hsk_ack_i,
  input  logic       out_ready_i,
  input  usb_pid_e   out_parity_i,
  input  logic       in_ready_i,
  input  usb_tx_t    in_tx_i,
  input  logic       tx_ready_i,
  output usb_hsk_t   hsk_o,
  output usb_tx_t    tx_o,
  output logic       in_tx_ready_o,
  output logic       out_sel_o,
  output logic       out_commit_o,
  output logic       in_sel_o,
  output logic       in_ack_o,
  output logic       in_retry_o
);

  typedef enum logic [2:0] {
    IDLE,
    OUT_DATA,
    OUT_HSK,
    IN_SEND,
    IN_WAIT
  } state_e;

  state_e state_q;
  usb_hsk_t hsk_q;
  logic accept_q;  // OUT buffer was empty at the token
  logic good_q;  // data PID matched the toggle
  logic tok_ok;
  logic out_tok;
  logic ping_tok;
  logic in_tok;
  logic rx_end;
  logic tx_end;

  // only tokens for this device, once configured
  assign tok_ok = tok_i.valid && configured_i && (tok_i.addr == usb_addr_i);
  assign out_tok = tok_ok && (tok_i.pid == PID_OUT) && (tok_i.endp == EP_OUT_NUM);
  assign ping_tok = tok_ok && (tok_i.pid == PID_PING) && (tok_i.endp == EP_OUT_NUM);
  assign in_tok = tok_ok && (tok_i.pid == PID_IN) && (tok_i.endp == EP_IN_NUM);
  assign rx_end = rx_i.valid && rx_i.last;
  assign tx_end = tx_o.valid && tx_ready_i && tx_o.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      hsk_q.valid <= 1'b0;
    end else begin
      hsk_q.valid <= 1'b0;
      case (state_q)
        OUT_DATA: begin
          if (rx_end) begin
            state_q <= OUT_HSK;
            hsk_q.valid <= 1'b1;
            hsk_q.pid <= accept_q ? PID_ACK : PID_NAK;
            good_q <= accept_q && (rx_i.pid == out_parity_i);
          end else if (tok_i.valid) begin
            state_q <= IDLE;  // data packet lost, stay silent
          end
        end
        OUT_HSK: state_q <= IDLE;
        IN_SEND: begin
          if (tx_end) state_q <= IN_WAIT;
        end
        default: begin
          // IDLE, or IN_WAIT where any token also ends the wait
          if (state_q == IN_WAIT && (hsk_ack_i || tok_i.valid)) state_q <= IDLE;
          if (out_tok) begin
            state_q <= OUT_DATA;
            accept_q <= out_ready_i;
          end else if (ping_tok) begin
            hsk_q.valid <= 1'b1;
            hsk_q.pid <= out_ready_i ? PID_ACK : PID_NAK;
          end else if (in_tok) begin
            if (in_ready_i) begin
              state_q <= IN_SEND;
            end else begin
              hsk_q.valid <= 1'b1;
              hsk_q.pid <= PID_NAK;
            end
          end
        end
      endcase
    end
  end

  assign hsk_o = hsk_q;
  assign out_sel_o = (state_q == OUT_DATA) || (state_q == OUT_HSK);
  assign out_commit_o = (state_q == OUT_HSK) && good_q;
  assign in_sel_o = (state_q == IN_SEND);
  assign in_ack_o = (state_q == IN_WAIT) && hsk_ack_i;
  assign in_retry_o = (state_q == IN_WAIT) && !hsk_ack_i && tok_i.valid;
  assign in_tx_ready_o = tx_ready_i && (state_q == IN_SEND);

  always_comb begin
    tx_o = in_tx_i;
    tx_o.valid = in_tx_i.valid && (state_q == IN_SEND);
  end

  assert property (@(posedge clock) disable iff (reset)
    hsk_o.valid |-> hsk_o.pid inside {PID_ACK, PID_NAK});

endmodule

// ==== verilog/ep_bulk_in.sv ====
module ep_bulk_in
  import usb_bulk_pkg::*;
#(
  parameter integer MAX_PKT = MAX_PKT_DEFAULT
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         configured_i,
  input  logic         sel_i,
  input  logic         ack_i,
  input  logic         retry_i,
  input  byte_stream_t blki_i,
  input  logic         tx_ready_i,
  output logic         blki_ready_o,
  output logic         ready_o,
  output usb_tx_t      tx_o
);

  logic toggle_q;
  logic wr;
  logic rd;
  logic full;
  logic rd_last;
  logic [7:0] rd_data;

  assign wr = blki_i.valid && blki_ready_o;
  assign rd = tx_o.valid && tx_ready_i;

  always_ff @(posedge clock) begin
    if (reset || !configured_i) begin
      toggle_q <= 1'b0;
    end else if (ack_i) begin
      toggle_q <= ~toggle_q;  // host has the packet
    end
  end

  packet_buffer #(
    .MAX_PKT(MAX_PKT)
  ) u_packet_buffer (
    .clock    (clock),
    .reset    (reset),
    .wr_i     (wr),
    .wr_data_i(blki_i.data),
    .wr_last_i(blki_i.last),
    .rd_i     (rd),
    .rewind_i (retry_i),  // resend same bytes on the next IN
    .release_i(ack_i),
    .drop_i   (1'b0),
    .full_o   (full),
    .empty_o  (),
    .rd_data_o(rd_data),
    .rd_last_o(rd_last)
  );

  assign blki_ready_o = !full;
  assign ready_o = full;
  assign tx_o.valid = sel_i && full;
  assign tx_o.last = rd_last;
  assign tx_o.pid = toggle_q ? PID_DATA1 : PID_DATA0;
  assign tx_o.data = rd_data;

endmodule

// ==== verilog/ep_bulk_out.sv ====
module ep_bulk_out
  import usb_bulk_pkg::*;
#(
  parameter integer MAX_PKT = MAX_PKT_DEFAULT
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         configured_i,
  input  logic         sel_i,
  input  logic         commit_i,
  input  usb_rx_t      rx_i,
  input  logic         blko_ready_i,
  output logic         ready_o,
  output usb_pid_e     parity_o,
  output byte_stream_t blko_o
);

  logic toggle_q;
  logic sel_q;
  logic wrote_q;  // bytes of the current transaction are in the buffer
  logic kept_q;
  logic wr;
  logic rd;
  logic drop;
  logic pkt_done;
  logic full;
  logic empty;
  logic rd_last;
  logic [7:0] rd_data;

  // a packet only starts into an empty buffer
  assign wr = sel_i && rx_i.valid && (wrote_q || empty);
  assign drop = sel_q && !sel_i && wrote_q && !kept_q;  // NAK'd or duplicate
  assign rd = blko_o.valid && blko_ready_i;
  assign pkt_done = rd && rd_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
      wrote_q <= 1'b0;
      kept_q <= 1'b0;
      toggle_q <= 1'b0;
    end else begin
      sel_q <= sel_i;
      if (!sel_i) wrote_q <= 1'b0;
      else if (wr) wrote_q <= 1'b1;
      if (!sel_i) kept_q <= 1'b0;
      else if (commit_i) kept_q <= 1'b1;
      if (!configured_i) toggle_q <= 1'b0;
      else if (commit_i) toggle_q <= ~toggle_q;
    end
  end

  packet_buffer #(
    .MAX_PKT(MAX_PKT)
  ) u_packet_buffer (
    .clock    (clock),
    .reset    (reset),
    .wr_i     (wr),
    .wr_data_i(rx_i.data),
    .wr_last_i(rx_i.last),
    .rd_i     (rd),
    .rewind_i (1'b0),
    .release_i(pkt_done),
    .drop_i   (drop),
    .full_o   (full),
    .empty_o  (empty),
    .rd_data_o(rd_data),
    .rd_last_o(rd_last)
  );

  assign ready_o = empty;
  assign parity_o = toggle_q ? PID_DATA1 : PID_DATA0;
  // hold off the drain until the transaction that wrote it has closed
  assign blko_o.valid = full && !wrote_q;
  assign blko_o.last = rd_last;
  assign blko_o.data = rd_data;

  // the engine only commits a packet this endpoint actually stored
  assert property (@(posedge clock) disable iff (reset)
    commit_i |-> wrote_q && full);

endmodule

// ==== verilog/packet_buffer.sv ====
module packet_buffer
  import usb_bulk_pkg::*;
#(
  parameter integer MAX_PKT = MAX_PKT_DEFAULT
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       wr_i,
  input  logic [7:0] wr_data_i,
  input  logic       wr_last_i,
  input  logic       rd_i,
  input  logic       rewind_i,
  input  logic       release_i,
  input  logic       drop_i,
  output logic       full_o,
  output logic       empty_o,
  output logic [7:0] rd_data_o,
  output logic       rd_last_o
);

  localparam integer AW = $clog2(MAX_PKT);
  localparam integer CW = $clog2(MAX_PKT + 1);  // count reaches MAX_PKT

  logic [7:0] mem [MAX_PKT];
  logic [CW-1:0] count_q;
  logic [CW-1:0] rd_ptr_q;
  logic full_q;

  always_ff @(posedge clock) begin
    if (wr_i) begin
      mem[count_q[AW-1:0]] <= wr_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || release_i || drop_i) begin  // both empty the buffer
      count_q <= '0;
      rd_ptr_q <= '0;
      full_q <= 1'b0;
    end else begin
      if (wr_i) begin
        count_q <= count_q + CW'(1);
        if (wr_last_i) full_q <= 1'b1;  // packet complete
      end
      if (rewind_i) begin
        rd_ptr_q <= '0;
      end else if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + CW'(1);
      end
    end
  end

  assign full_o = full_q;
  assign empty_o = (count_q == '0);
  assign rd_data_o = mem[rd_ptr_q[AW-1:0]];
  assign rd_last_o = (rd_ptr_q + CW'(1)) == count_q;

  // no write into a finished packet, and never past the end of the RAM
  assert property (@(posedge clock) disable iff (reset)
    wr_i |-> !full_q && (count_q < CW'(MAX_PKT)));

endmodule

// ==== verilog/usb_bulk_pkg.sv ====
package usb_bulk_pkg;

  // 4-bit PID, check nibble already stripped by the decoder
  typedef enum logic [3:0] {
    PID_OUT   = 4'h1,
    PID_IN    = 4'h9,
    PID_SOF   = 4'h5,
    PID_SETUP = 4'hd,
    PID_PING  = 4'h4,
    PID_DATA0 = 4'h3,
    PID_DATA1 = 4'hb,
    PID_ACK   = 4'h2,
    PID_NAK   = 4'ha
  } usb_pid_e;

  typedef struct packed {
    logic       valid;
    usb_pid_e   pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_token_t;

  // one data-packet byte from the host
  typedef struct packed {
    logic       valid;
    logic       last;
    usb_pid_e   pid;
    logic [7:0] data;
  } usb_rx_t;

  // one data-packet byte towards the host
  typedef struct packed {
    logic       valid;
    logic       last;
    usb_pid_e   pid;
    logic [7:0] data;
  } usb_tx_t;

  typedef struct packed {
    logic     valid;
    usb_pid_e pid;
  } usb_hsk_t;

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } byte_stream_t;

  localparam logic [3:0] EP_OUT_NUM = 4'd1;  // bulk OUT
  localparam logic [3:0] EP_IN_NUM = 4'd2;  // bulk IN
  localparam integer MAX_PKT_DEFAULT = 64;

endpackage

// ==== verilog/usb_bulk_top.sv ====
module usb_bulk_top
  import usb_bulk_pkg::*;
#(
  parameter integer MAX_PKT = MAX_PKT_DEFAULT
) (
  input  logic         clock,
  input  logic         reset,
  input  logic [6:0]   usb_addr_i,
  input  logic         configured_i,
  input  usb_token_t   tok_i,
  input  usb_rx_t      rx_i,
  input  logic         hsk_ack_i,
  output usb_hsk_t     hsk_o,
  output usb_tx_t      tx_o,
  input  logic         tx_ready_i,
  output byte_stream_t blko_o,
  input  logic         blko_ready_i,
  input  byte_stream_t blki_i,
  output logic         blki_ready_o
);

  logic out_sel;
  logic out_commit;
  logic out_ready;
  usb_pid_e out_parity;
  logic in_sel;
  logic in_ack;
  logic in_retry;
  logic in_ready;
  logic in_tx_ready;
  usb_tx_t in_tx;

  bulk_protocol u_bulk_protocol (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr_i),
    .configured_i (configured_i),
    .tok_i        (tok_i),
    .rx_i         (rx_i),
    .hsk_ack_i    (hsk_ack_i),
    .out_ready_i  (out_ready),
    .out_parity_i (out_parity),
    .in_ready_i   (in_ready),
    .in_tx_i      (in_tx),
    .tx_ready_i   (tx_ready_i),
    .hsk_o        (hsk_o),
    .tx_o         (tx_o),
    .in_tx_ready_o(in_tx_ready),
    .out_sel_o    (out_sel),
    .out_commit_o (out_commit),
    .in_sel_o     (in_sel),
    .in_ack_o     (in_ack),
    .in_retry_o   (in_retry)
  );

  ep_bulk_out #(
    .MAX_PKT(MAX_PKT)
  ) u_ep_bulk_out (
    .clock       (clock),
    .reset       (reset),
    .configured_i(configured_i),
    .sel_i       (out_sel),
    .commit_i    (out_commit),
    .rx_i        (rx_i),
    .blko_ready_i(blko_ready_i),
    .ready_o     (out_ready),
    .parity_o    (out_parity),
    .blko_o      (blko_o)
  );

  ep_bulk_in #(
    .MAX_PKT(MAX_PKT)
  ) u_ep_bulk_in (
    .clock       (clock),
    .reset       (reset),
    .configured_i(configured_i),
    .sel_i       (in_sel),
    .ack_i       (in_ack),
    .retry_i     (in_retry),
    .blki_i      (blki_i),
    .tx_ready_i  (in_tx_ready),
    .blki_ready_o(blki_ready_o),
    .ready_o     (in_ready),
    .tx_o        (in_tx)
  );

endmodule
